//--- src.f
src/wvb_pkg.sv
src/pretrigger_buffer.sv
src/wvb_wr_ctrl.sv
src/wvb_storage.sv
src/waveform_buffer.sv
testbench/waveform_buffer_properties.sv
testbench/tb_waveform_buffer.sv

//--- Bender.yml
package:
  name: waveform_buffer

sources:
  - src/wvb_pkg.sv
  - src/pretrigger_buffer.sv
  - src/wvb_wr_ctrl.sv
  - src/wvb_storage.sv
  - src/waveform_buffer.sv
  - target: test
    files:
      - testbench/waveform_buffer_properties.sv
      - testbench/tb_waveform_buffer.sv

//--- testbench/tb_waveform_buffer.sv
`timescale 1ns/1ps
// ****************************************
// Testbench for the waveform buffer. Runs
// random capture and read-out phases and
// checks headers and words against a model.
// ****************************************

module tb_waveform_buffer;
  import wvb_pkg::*;

  localparam int N_PHASES       = 4;
  localparam int N_ROUNDS       = 10;
  localparam int MAX_WIN        = PTB_DEPTH + 2 ** POST_WIDTH - 1;
  localparam int ROUND_CYCLES   = 2 * MAX_WIN + 40;
  localparam int READ_CYCLES    = 3 * WVB_DEPTH + 4 * HDR_DEPTH;
  localparam int TEST_CYCLES    = 60 + N_PHASES * (N_ROUNDS * ROUND_CYCLES + READ_CYCLES);
  localparam int TIMEOUT_CYCLES = 20 * TEST_CYCLES;
  localparam int LOG_DEPTH      = 65536;

  typedef struct {
    wvb_hdr_t hdr;
    int       first;
    int       len;
  } exp_t;

  logic                   clk;
  logic                   reset;
  logic [ADC_WIDTH-1:0]   adc_in;
  logic [DISCR_WIDTH-1:0] discr_in;
  logic                   tot;
  logic [LTC_WIDTH-1:0]   ltc_in;
  logic                   trig;
  logic [SRC_WIDTH-1:0]   trig_src;
  logic                   arm;
  logic [PRE_WIDTH-1:0]   pre_conf;
  logic [POST_WIDTH-1:0]  post_conf;
  logic                   wvb_rdreq;
  logic                   wvb_rddone;
  logic                   armed;
  logic                   overflow;
  logic [USED_WIDTH-1:0]  wvb_used;
  logic [NWVF_WIDTH-1:0]  n_wvf_in_buf;
  logic                   hdr_empty;
  logic                   hdr_full;
  wvb_hdr_t               hdr_out;
  wvb_sample_t            wvb_data_out;

  // Model state and input log
  logic [31:0]          rng_state;
  int                   errors = 0;
  int                   cyc;
  int                   wd_cycles = 0;
  wvb_sample_t          sample_log [LOG_DEPTH];
  logic [LTC_WIDTH-1:0] ltc_log [LOG_DEPTH];
  logic [LTC_WIDTH-1:0] ltc_base;
  logic                 rst_v;
  logic                 nxt_trig;
  logic                 nxt_arm;
  logic                 nxt_rdreq;
  logic                 nxt_rddone;
  logic [SRC_WIDTH-1:0] nxt_src;
  int                   cfg_pre;
  int                   cfg_post;
  exp_t                 exp_q [$];
  logic                 m_armed;
  logic                 m_overflow;
  int                   m_used;
  int                   m_wptr;

  initial clk = 1'b0;
  always #10 clk = ~clk;

  waveform_buffer waveform_buffer_inst (.*);

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  task automatic check_value(input string name, input logic [127:0] actual,
                             input logic [127:0] expected);
    if (actual !== expected) begin
      errors++;
      $display("** Error %s: got 0x%0h, expected 0x%0h at %0t", name, actual, expected, $time);
    end
  endtask

  // One clock: new sample on every edge, pulses clear after use
  task automatic tick();
    logic [31:0] rnd;
    wvb_sample_t s;
    @(posedge clk);
    rnd = next_rand();
    s = rnd[20:0];
    sample_log[cyc % LOG_DEPTH] = s;
    ltc_log[cyc % LOG_DEPTH] = ltc_base + LTC_WIDTH'(cyc);
    reset      <= rst_v;
    adc_in     <= s.adc;
    discr_in   <= s.discr;
    tot        <= s.tot;
    ltc_in     <= ltc_base + LTC_WIDTH'(cyc);
    trig       <= nxt_trig;
    trig_src   <= nxt_src;
    arm        <= nxt_arm;
    pre_conf   <= PRE_WIDTH'(cfg_pre);
    post_conf  <= POST_WIDTH'(cfg_post);
    wvb_rdreq  <= nxt_rdreq;
    wvb_rddone <= nxt_rddone;
    nxt_trig   = 1'b0;
    nxt_arm    = 1'b0;
    nxt_rdreq  = 1'b0;
    nxt_rddone = 1'b0;
    cyc++;
    @(negedge clk);
  endtask

  task automatic capture_round();
    logic [31:0] rnd;
    int          t_idx;
    int          win;
    exp_t        e;
    // Window size only changes while disarmed
    if (!m_armed) begin
      rnd = next_rand();
      cfg_pre  = rnd[4:0];
      cfg_post = rnd[15:8];
      tick();
      nxt_arm = 1'b1;
      tick();
      tick();
      check_value("armed", armed, 1);
      m_armed = 1'b1;
    end
    rnd = next_rand();
    repeat (rnd[3:0]) tick();
    nxt_src  = rnd[9:8];
    nxt_trig = 1'b1;
    t_idx = cyc;
    tick();
    tick();
    win = cfg_pre + cfg_post + 1;
    if ((WVB_DEPTH - m_used >= win) && (exp_q.size() < HDR_DEPTH)) begin
      e.hdr.start_addr = ADR_WIDTH'(m_wptr);
      e.hdr.stop_addr  = ADR_WIDTH'(m_wptr + win - 1);
      e.hdr.ltc        = ltc_log[t_idx % LOG_DEPTH];
      e.hdr.trig_src   = nxt_src;
      e.first = t_idx - cfg_pre;
      e.len   = win;
      exp_q.push_back(e);
      m_wptr  = (m_wptr + win) % WVB_DEPTH;
      m_used  = m_used + win;
      m_armed = 1'b0;
      check_value("armed", armed, 0);
      while (n_wvf_in_buf != exp_q.size()) tick();
      check_value("wvb_used", wvb_used, m_used);
      // Trigger while disarmed must leave no trace
      nxt_trig = 1'b1;
      tick();
      // Long enough for a wrongly taken window to reach the FIFO
      repeat (win + 2) tick();
      check_value("armed", armed, 0);
      check_value("n_wvf_in_buf", n_wvf_in_buf, exp_q.size());
      check_value("wvb_used", wvb_used, m_used);
    end else begin
      m_overflow = 1'b1;
      check_value("armed", armed, 1);
      check_value("hdr_full", hdr_full, exp_q.size() == HDR_DEPTH);
    end
    check_value("overflow", overflow, m_overflow);
  endtask

  task automatic read_out();
    exp_t e;
    while (exp_q.size() > 0) begin
      tick();
      tick();
      check_value("n_wvf_in_buf", n_wvf_in_buf, exp_q.size());
      check_value("wvb_used", wvb_used, m_used);
      check_value("hdr_empty", hdr_empty, 0);
      e = exp_q.pop_front();
      check_value("hdr_out", hdr_out, e.hdr);
      for (int k = 0; k < e.len; k++) begin
        // Data follows the pointer two cycles later
        if (k > 0) begin
          nxt_rdreq = 1'b1;
          tick();
          tick();
          tick();
        end
        check_value("wvb_data_out", wvb_data_out, sample_log[(e.first + k) % LOG_DEPTH]);
      end
      nxt_rddone = 1'b1;
      tick();
      m_used = m_used - e.len;
    end
    tick();
    tick();
    check_value("hdr_empty", hdr_empty, 1);
    check_value("n_wvf_in_buf", n_wvf_in_buf, 0);
    check_value("wvb_used", wvb_used, m_used);
  endtask

  initial begin
    rng_state  = 32'd86;
    cyc        = 0;
    rst_v      = 1'b1;
    nxt_trig   = 1'b0;
    nxt_arm    = 1'b0;
    nxt_rdreq  = 1'b0;
    nxt_rddone = 1'b0;
    nxt_src    = '0;
    cfg_pre    = 0;
    cfg_post   = 0;
    m_armed    = 1'b0;
    m_overflow = 1'b0;
    m_used     = 0;
    m_wptr     = 0;
    reset      = 1'b1;
    adc_in     = '0;
    discr_in   = '0;
    tot        = 1'b0;
    ltc_in     = '0;
    trig       = 1'b0;
    trig_src   = '0;
    arm        = 1'b0;
    pre_conf   = '0;
    post_conf  = '0;
    wvb_rdreq  = 1'b0;
    wvb_rddone = 1'b0;
    ltc_base   = {16'h0, next_rand()} << 12;
    repeat (10) tick();
    rst_v = 1'b0;
    repeat (3) tick();
    check_value("armed", armed, 0);
    check_value("overflow", overflow, 0);
    check_value("hdr_empty", hdr_empty, 1);
    check_value("wvb_used", wvb_used, 0);
    check_value("n_wvf_in_buf", n_wvf_in_buf, 0);
    // Fill the delay line before the first arm
    repeat (40) tick();
    for (int p = 0; p < N_PHASES; p++) begin
      for (int r = 0; r < N_ROUNDS; r++) begin
        capture_round();
      end
      read_out();
    end
    $display("Run complete with %0d errors", errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  always @(posedge clk) begin
    wd_cycles <= wd_cycles + 1;
    if (wd_cycles == TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Run stopped with %0d errors", errors);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

endmodule

//--- testbench/waveform_buffer_properties.sv
`timescale 1ns/1ps
// ****************************************
// Concurrent checks on the waveform buffer
// top level, attached with bind.
// ****************************************

module waveform_buffer_properties (
  input logic                           clk,
  input logic                           reset,
  input logic                           i_reset,
  input logic                           trig,
  input logic                           ptb_rdy,
  input logic [wvb_pkg::PRE_WIDTH-1:0]  pre_conf,
  input logic [wvb_pkg::POST_WIDTH-1:0] post_conf,
  input logic [wvb_pkg::USED_WIDTH-1:0] wvb_used,
  input logic                           hdr_full,
  input logic                           hdr_wr,
  input logic                           wvb_rddone,
  input logic                           armed,
  input logic                           overflow,
  input logic                           hdr_empty,
  input logic [wvb_pkg::NWVF_WIDTH-1:0] n_wvf_in_buf
);
  import wvb_pkg::*;

  logic [USED_WIDTH-1:0] win_len;
  logic                  trig_fits;
  logic [NWVF_WIDTH-1:0] hdr_cnt;

  // Window length and room at the trigger
  assign win_len   = USED_WIDTH'(pre_conf) + USED_WIDTH'(post_conf) + 1'b1;
  assign trig_fits = (USED_WIDTH'(WVB_DEPTH) - wvb_used >= win_len) && !hdr_full;

  // Headers written and not yet popped
  always_ff @(posedge clk) begin
    if (i_reset) begin
      hdr_cnt <= '0;
    end else begin
      hdr_cnt <= hdr_cnt + NWVF_WIDTH'(hdr_wr)
                 - NWVF_WIDTH'(wvb_rddone && (hdr_cnt != '0));
    end
  end

  // Sticky until the internal reset
  overflow_sticky: assert property (@(posedge clk) (!i_reset && overflow) |=> overflow)
    else $error("overflow fell without reset");

  nwvf_bounded: assert property (@(posedge clk) disable iff (reset || i_reset)
    n_wvf_in_buf <= NWVF_WIDTH'(HDR_DEPTH))
    else $error("n_wvf_in_buf above header FIFO depth");

  empty_matches_count: assert property (@(posedge clk) disable iff (reset || i_reset)
    (hdr_empty == (hdr_cnt == '0)) && (n_wvf_in_buf == hdr_cnt))
    else $error("hdr_empty or n_wvf_in_buf disagrees with the header count");

  // A trigger that fits disarms the channel
  trig_disarms: assert property (@(posedge clk) disable iff (reset || i_reset)
    (armed && trig && ptb_rdy && trig_fits) |=> !armed)
    else $error("armed still high after an accepted trigger");

endmodule

bind waveform_buffer waveform_buffer_properties props_inst (
  .clk          (clk),
  .reset        (reset),
  .i_reset      (i_reset),
  .trig         (trig),
  .ptb_rdy      (ptb_rdy),
  .pre_conf     (pre_conf),
  .post_conf    (post_conf),
  .wvb_used     (wvb_used),
  .hdr_full     (hdr_full),
  .hdr_wr       (hdr_wr),
  .wvb_rddone   (wvb_rddone),
  .armed        (armed),
  .overflow     (overflow),
  .hdr_empty    (hdr_empty),
  .n_wvf_in_buf (n_wvf_in_buf)
);

//--- src/waveform_buffer.sv
`timescale 1ns/1ps
// ****************************************
// Waveform buffer for one digitizer
// channel. Captures a window around each
// accepted trigger for strobe read-out.
// ****************************************

module waveform_buffer (
  input  logic                           clk,
  input  logic                           reset,
  input  logic [wvb_pkg::ADC_WIDTH-1:0]  adc_in,
  input  logic [wvb_pkg::DISCR_WIDTH-1:0] discr_in,
  input  logic                           tot,
  input  logic [wvb_pkg::LTC_WIDTH-1:0]  ltc_in,
  input  logic                           trig,
  input  logic [wvb_pkg::SRC_WIDTH-1:0]  trig_src,
  input  logic                           arm,
  input  logic [wvb_pkg::PRE_WIDTH-1:0]  pre_conf,
  input  logic [wvb_pkg::POST_WIDTH-1:0] post_conf,
  input  logic                           wvb_rdreq,
  input  logic                           wvb_rddone,
  output logic                           armed,
  output logic                           overflow,
  output logic [wvb_pkg::USED_WIDTH-1:0] wvb_used,
  output logic [wvb_pkg::NWVF_WIDTH-1:0] n_wvf_in_buf,
  output logic                           hdr_empty,
  output logic                           hdr_full,
  output wvb_pkg::wvb_hdr_t              hdr_out,
  output wvb_pkg::wvb_sample_t           wvb_data_out
);
  import wvb_pkg::*;

  logic                 i_reset;
  wvb_sample_t          sample_in;
  wvb_sample_t          ptb_out;
  logic                 ptb_rdy;
  logic                 wr_en;
  logic [ADR_WIDTH-1:0] wr_addr;
  logic                 hdr_wr;
  wvb_hdr_t             hdr_in;

  // Registered once, shared by all blocks
  always_ff @(posedge clk) begin
    i_reset <= reset;
  end

  assign sample_in = '{adc: adc_in, discr: discr_in, tot: tot};

  pretrigger_buffer ptb_inst (
    .clk       (clk),
    .reset     (i_reset),
    .sample_in (sample_in),
    .pre_conf  (pre_conf),
    .ptb_out   (ptb_out),
    .ptb_rdy   (ptb_rdy)
  );

  wvb_wr_ctrl wr_ctrl_inst (
    .clk       (clk),
    .reset     (i_reset),
    .ltc_in    (ltc_in),
    .trig      (trig),
    .trig_src  (trig_src),
    .arm       (arm),
    .pre_conf  (pre_conf),
    .post_conf (post_conf),
    .ptb_rdy   (ptb_rdy),
    .wvb_used  (wvb_used),
    .hdr_full  (hdr_full),
    .wr_en     (wr_en),
    .wr_addr   (wr_addr),
    .hdr_wr    (hdr_wr),
    .hdr_in    (hdr_in),
    .armed     (armed),
    .overflow  (overflow)
  );

  wvb_storage storage_inst (
    .clk          (clk),
    .reset        (i_reset),
    .wr_en        (wr_en),
    .wr_addr      (wr_addr),
    .wr_data      (ptb_out),
    .hdr_wr       (hdr_wr),
    .hdr_in       (hdr_in),
    .wvb_rdreq    (wvb_rdreq),
    .wvb_rddone   (wvb_rddone),
    .wvb_data_out (wvb_data_out),
    .hdr_out      (hdr_out),
    .hdr_empty    (hdr_empty),
    .hdr_full     (hdr_full),
    .n_wvf_in_buf (n_wvf_in_buf),
    .wvb_used     (wvb_used)
  );

endmodule

//--- src/wvb_storage.sv
`timescale 1ns/1ps
// ****************************************
// Sample RAM and header FIFO. Tracks the
// read pointer for the waveform at the
// head of the FIFO and the words in use.
// ****************************************

module wvb_storage (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           wr_en,
  input  logic [wvb_pkg::ADR_WIDTH-1:0]  wr_addr,
  input  wvb_pkg::wvb_sample_t           wr_data,
  input  logic                           hdr_wr,
  input  wvb_pkg::wvb_hdr_t              hdr_in,
  input  logic                           wvb_rdreq,
  input  logic                           wvb_rddone,
  output wvb_pkg::wvb_sample_t           wvb_data_out,
  output wvb_pkg::wvb_hdr_t              hdr_out,
  output logic                           hdr_empty,
  output logic                           hdr_full,
  output logic [wvb_pkg::NWVF_WIDTH-1:0] n_wvf_in_buf,
  output logic [wvb_pkg::USED_WIDTH-1:0] wvb_used
);
  import wvb_pkg::*;

  wvb_sample_t              sample_ram [WVB_DEPTH];
  wvb_hdr_t                 hdr_ram [HDR_DEPTH];
  logic [HDR_ADR_WIDTH-1:0] hdr_wptr;
  logic [HDR_ADR_WIDTH-1:0] hdr_rptr;
  logic [HDR_ADR_WIDTH-1:0] hdr_next;
  logic [ADR_WIDTH-1:0]     rd_ptr;
  logic [ADR_WIDTH-1:0]     wvf_len;
  logic [USED_WIDTH-1:0]    freed;
  logic                     pop;

  assign pop       = wvb_rddone && !hdr_empty;
  assign hdr_next  = hdr_rptr + 1'b1;
  assign hdr_out   = hdr_ram[hdr_rptr];
  assign hdr_empty = (n_wvf_in_buf == '0);
  assign hdr_full  = (n_wvf_in_buf == NWVF_WIDTH'(HDR_DEPTH));

  // Length wraps with the memory
  assign wvf_len = hdr_out.stop_addr - hdr_out.start_addr + 1'b1;
  assign freed   = pop ? USED_WIDTH'(wvf_len) : '0;

  always_ff @(posedge clk) begin
    if (wr_en) begin
      sample_ram[wr_addr] <= wr_data;
    end
    wvb_data_out <= sample_ram[rd_ptr];
  end

  always_ff @(posedge clk) begin
    if (hdr_wr) begin
      hdr_ram[hdr_wptr] <= hdr_in;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      hdr_wptr     <= '0;
      hdr_rptr     <= '0;
      n_wvf_in_buf <= '0;
      wvb_used     <= '0;
    end else begin
      if (hdr_wr) begin
        hdr_wptr <= hdr_wptr + 1'b1;
      end
      if (pop) begin
        hdr_rptr <= hdr_next;
      end
      case ({hdr_wr, pop})
        2'b10:   n_wvf_in_buf <= n_wvf_in_buf + 1'b1;
        2'b01:   n_wvf_in_buf <= n_wvf_in_buf - 1'b1;
        default: n_wvf_in_buf <= n_wvf_in_buf;
      endcase
      wvb_used <= wvb_used + USED_WIDTH'(wr_en) - freed;
    end
  end

  // Pointer reloads whenever a new header reaches the head
  always_ff @(posedge clk) begin
    if (reset) begin
      rd_ptr <= '0;
    end else if (pop && (n_wvf_in_buf > NWVF_WIDTH'(1))) begin
      rd_ptr <= hdr_ram[hdr_next].start_addr;
    end else if (hdr_wr && (hdr_empty || pop)) begin
      rd_ptr <= hdr_in.start_addr;
    end else if (wvb_rdreq) begin
      rd_ptr <= rd_ptr + 1'b1;
    end
  end

endmodule

//--- src/wvb_wr_ctrl.sv
`timescale 1ns/1ps
// ****************************************
// Write controller. Arms the channel,
// accepts triggers that fit, steps the
// write address over the window and
// builds the header for each capture.
// ****************************************

module wvb_wr_ctrl (
  input  logic                           clk,
  input  logic                           reset,
  input  logic [wvb_pkg::LTC_WIDTH-1:0]  ltc_in,
  input  logic                           trig,
  input  logic [wvb_pkg::SRC_WIDTH-1:0]  trig_src,
  input  logic                           arm,
  input  logic [wvb_pkg::PRE_WIDTH-1:0]  pre_conf,
  input  logic [wvb_pkg::POST_WIDTH-1:0] post_conf,
  input  logic                           ptb_rdy,
  input  logic [wvb_pkg::USED_WIDTH-1:0] wvb_used,
  input  logic                           hdr_full,
  output logic                           wr_en,
  output logic [wvb_pkg::ADR_WIDTH-1:0]  wr_addr,
  output logic                           hdr_wr,
  output wvb_pkg::wvb_hdr_t              hdr_in,
  output logic                           armed,
  output logic                           overflow
);
  import wvb_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE,
    S_ARMED,
    S_WRITE,
    S_HDR
  } state_t;

  state_t                state;
  logic [ADR_WIDTH-1:0]  wr_ptr;
  logic [WIN_WIDTH-1:0]  win_len;
  logic [WIN_WIDTH-1:0]  remaining;
  logic [USED_WIDTH-1:0] free_words;
  logic                  fits;
  logic                  accept;
  logic                  drop;
  logic                  last_write;
  wvb_hdr_t              hdr_q;

  // Window is pre + trigger sample + post
  assign win_len    = WIN_WIDTH'(pre_conf) + WIN_WIDTH'(post_conf) + 1'b1;
  assign free_words = USED_WIDTH'(WVB_DEPTH) - wvb_used;
  assign fits       = (free_words >= USED_WIDTH'(win_len)) && !hdr_full;

  assign accept = (state == S_ARMED) && trig && ptb_rdy && fits;
  assign drop   = (state == S_ARMED) && trig && ptb_rdy && !fits;

  assign last_write = wr_en && (remaining == WIN_WIDTH'(1));

  assign armed   = (state == S_ARMED);
  assign wr_en   = (state == S_WRITE);
  assign hdr_wr  = (state == S_HDR);
  assign wr_addr = wr_ptr;
  assign hdr_in  = hdr_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= S_IDLE;
      wr_ptr    <= '0;
      remaining <= '0;
      overflow  <= 1'b0;
    end else begin
      // Sticky until reset
      if (drop) begin
        overflow <= 1'b1;
      end
      case (state)
        S_IDLE, S_HDR: begin
          state <= arm ? S_ARMED : S_IDLE;
        end
        S_ARMED: begin
          if (accept) begin
            state     <= S_WRITE;
            remaining <= win_len;
          end
        end
        S_WRITE: begin
          wr_ptr    <= wr_ptr + 1'b1;
          remaining <= remaining - 1'b1;
          if (last_write) begin
            state <= S_HDR;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // Start, time and source at the trigger, stop at the last write
  always_ff @(posedge clk) begin
    if (accept) begin
      hdr_q.start_addr <= wr_ptr;
      hdr_q.ltc        <= ltc_in;
      hdr_q.trig_src   <= trig_src;
    end
    if (last_write) begin
      hdr_q.stop_addr <= wr_ptr;
    end
  end

endmodule

//--- src/pretrigger_buffer.sv
`timescale 1ns/1ps
// ****************************************
// Delay line that holds the samples ahead
// of a trigger. Output lags the input by
// pre_conf + 1 cycles.
// ****************************************

module pretrigger_buffer (
  input  logic                          clk,
  input  logic                          reset,
  input  wvb_pkg::wvb_sample_t          sample_in,
  input  logic [wvb_pkg::PRE_WIDTH-1:0] pre_conf,
  output wvb_pkg::wvb_sample_t          ptb_out,
  output logic                          ptb_rdy
);
  import wvb_pkg::*;

  wvb_sample_t          ring [PTB_DEPTH];
  logic [PRE_WIDTH-1:0] wr_ptr;
  logic [PRE_WIDTH-1:0] rd_ptr;
  logic [PRE_WIDTH:0]   fill_cnt;

  // Tap sits pre_conf entries behind the newest sample
  assign rd_ptr = wr_ptr - pre_conf;

  always_ff @(posedge clk) begin
    ring[wr_ptr] <= sample_in;
    // With no delay the entry is still being written
    if (pre_conf == '0) begin
      ptb_out <= sample_in;
    end else begin
      ptb_out <= ring[rd_ptr];
    end
  end

  // Ready once enough history has entered the ring
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr   <= '0;
      fill_cnt <= '0;
      ptb_rdy  <= 1'b0;
    end else begin
      wr_ptr <= wr_ptr + 1'b1;
      if (!ptb_rdy) begin
        fill_cnt <= fill_cnt + 1'b1;
        if (fill_cnt >= {1'b0, pre_conf}) begin
          ptb_rdy <= 1'b1;
        end
      end
    end
  end

endmodule

//--- src/wvb_pkg.sv
// ****************************************
// Sizes and shared types for the channel
// waveform buffer. Every block imports it.
// ****************************************

package wvb_pkg;

  // Sample memory
  localparam int ADR_WIDTH  = 10;
  localparam int WVB_DEPTH  = 1024;
  localparam int USED_WIDTH = ADR_WIDTH + 1;

  // Window configuration
  localparam int PRE_WIDTH  = 5;
  localparam int POST_WIDTH = 8;
  localparam int PTB_DEPTH  = 2 ** PRE_WIDTH;
  // Holds pre + post + 1 at their maximum
  localparam int WIN_WIDTH  = POST_WIDTH + 1;

  // Header FIFO
  localparam int HDR_DEPTH     = 8;
  localparam int HDR_ADR_WIDTH = $clog2(HDR_DEPTH);
  localparam int NWVF_WIDTH    = $clog2(HDR_DEPTH + 1);

  // Input fields
  localparam int ADC_WIDTH   = 12;
  localparam int DISCR_WIDTH = 8;
  localparam int LTC_WIDTH   = 48;
  localparam int SRC_WIDTH   = 2;

  typedef struct packed {
    logic [ADC_WIDTH-1:0]   adc;
    logic [DISCR_WIDTH-1:0] discr;
    logic                   tot;
  } wvb_sample_t;

  // One entry per captured window
  typedef struct packed {
    logic [ADR_WIDTH-1:0] start_addr;
    logic [ADR_WIDTH-1:0] stop_addr;
    logic [LTC_WIDTH-1:0] ltc;
    logic [SRC_WIDTH-1:0] trig_src;
  } wvb_hdr_t;

endpackage
